// File: source/regblk_pkg.sv
package regblk_pkg;

  // ************************************************************************
  // widths.
  // ************************************************************************
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;
  localparam int ADDR_W = 16;
  localparam int OFS_W  = 9;   // byte offset inside reg_block_0.
  localparam int TRIG_W = 4;

  typedef logic [DATA_W-1:0] word_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [TRIG_W-1:0] trigger_t;
  typedef logic [OFS_W-1:0]  offset_t;

  // ************************************************************************
  // register map of reg_block_0.
  // ************************************************************************
  localparam offset_t CTRL_OFS    = 9'h000;
  localparam offset_t TRIGGER_OFS = 9'h004;
  localparam offset_t STATUS_OFS  = 9'h008;
  localparam offset_t HWVAL_OFS   = 9'h00C;
  localparam offset_t WINDOW_OFS  = 9'h100;  // forwarded to reg_block_1.
  localparam offset_t WINDOW_SIZE = 9'h080;

  localparam int BLK1_REGS = 4;

  // ************************************************************************
  // local bus and APB.
  // ************************************************************************
  typedef enum logic [1:0] {
    BUS_READ  = 2'b00,
    BUS_WRITE = 2'b01
  } bus_access_e;

  typedef enum logic [1:0] {
    BUS_OKAY         = 2'b00,
    BUS_SLAVE_ERROR  = 2'b10,
    BUS_DECODE_ERROR = 2'b11
  } bus_status_e;

  typedef struct packed {
    logic  psel;
    logic  penable;
    addr_t paddr;
    logic  pwrite;
    strb_t pstrb;
    word_t pwdata;
  } apb_req_t;

  typedef struct packed {
    logic  pready;
    word_t prdata;
    logic  pslverr;
  } apb_rsp_t;

  typedef struct packed {
    logic        valid;
    bus_access_e access;
    addr_t       address;
    word_t       write_data;
    strb_t       strobe;
  } bus_req_t;

  typedef struct packed {
    logic        ready;
    bus_status_e status;
    word_t       read_data;
  } bus_rsp_t;

  // byte lanes with strobe set take the new data.
  function automatic word_t apply_strobe(word_t old_word, word_t new_word, strb_t strb);
    word_t merged;
    merged = old_word;
    for (int i = 0; i < STRB_W; i++) begin
      if (strb[i]) begin
        merged[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return merged;
  endfunction

endpackage

// File: source/apb_reg_adapter.sv
module apb_reg_adapter (
  input  regblk_pkg::apb_req_t i_apb,
  output regblk_pkg::apb_rsp_t o_apb,
  output regblk_pkg::bus_req_t o_bus_req,
  input  regblk_pkg::bus_rsp_t i_bus_rsp
);

  logic access_phase;

  // valid only during the access phase, held by the master until pready.
  assign access_phase = i_apb.psel && i_apb.penable;

  always_comb begin
    o_bus_req.valid      = access_phase;
    o_bus_req.access     = i_apb.pwrite ? regblk_pkg::BUS_WRITE : regblk_pkg::BUS_READ;
    o_bus_req.address    = i_apb.paddr;
    o_bus_req.write_data = i_apb.pwdata;
    o_bus_req.strobe     = i_apb.pstrb;
  end

  // ************************************************************************
  // response path, no register stage.
  // ************************************************************************
  always_comb begin
    o_apb.pready  = i_bus_rsp.ready;
    o_apb.prdata  = i_bus_rsp.read_data;
    o_apb.pslverr = i_bus_rsp.status != regblk_pkg::BUS_OKAY;  // slave or decode error.
  end

endmodule

// File: source/reg_block_0.sv
module reg_block_0 #(
  parameter regblk_pkg::addr_t BASE_ADDRESS      = 16'h1000,
  parameter regblk_pkg::word_t DEFAULT_READ_DATA = 32'hDEAD_BEAF
) (
  input  logic                 clk,
  input  logic                 i_rst_n,
  input  regblk_pkg::apb_req_t i_apb,
  output regblk_pkg::apb_rsp_t o_apb,
  output regblk_pkg::bus_req_t o_fwd_req,
  input  regblk_pkg::bus_rsp_t i_fwd_rsp,
  output regblk_pkg::word_t    o_ctrl,
  output regblk_pkg::trigger_t o_trigger,
  input  regblk_pkg::trigger_t i_status_set,
  output regblk_pkg::trigger_t o_status,
  input  regblk_pkg::word_t    i_hw_value
);

  regblk_pkg::bus_req_t bus_req;
  regblk_pkg::bus_rsp_t bus_rsp;
  regblk_pkg::addr_t    rel_addr;
  regblk_pkg::offset_t  ofs;
  regblk_pkg::offset_t  word_ofs;
  regblk_pkg::offset_t  win_ofs;
  logic                 in_range;
  logic                 win_hit;
  logic                 sel_ctrl;
  logic                 sel_trigger;
  logic                 sel_status;
  logic                 sel_hwval;
  logic                 wr_fire;
  logic                 local_hit;
  regblk_pkg::word_t    local_rdata;
  regblk_pkg::word_t    ctrl_q;
  regblk_pkg::trigger_t trigger_q;
  regblk_pkg::trigger_t status_q;
  regblk_pkg::trigger_t status_clr;

  apb_reg_adapter u_adapter (
    .i_apb     (i_apb),
    .o_apb     (o_apb),
    .o_bus_req (bus_req),
    .i_bus_rsp (bus_rsp)
  );

  // ************************************************************************
  // address decode.
  // ************************************************************************
  assign rel_addr = bus_req.address - BASE_ADDRESS;  // wraps when below base.
  assign in_range = (rel_addr >> regblk_pkg::OFS_W) == '0;
  assign ofs      = rel_addr[regblk_pkg::OFS_W-1:0];
  assign word_ofs = {ofs[regblk_pkg::OFS_W-1:2], 2'b00};
  assign win_ofs  = ofs - regblk_pkg::WINDOW_OFS;

  assign win_hit = in_range && (ofs >= regblk_pkg::WINDOW_OFS) &&
                   (ofs < regblk_pkg::WINDOW_OFS + regblk_pkg::WINDOW_SIZE);

  assign sel_ctrl    = in_range && (word_ofs == regblk_pkg::CTRL_OFS);
  assign sel_trigger = in_range && (word_ofs == regblk_pkg::TRIGGER_OFS);
  assign sel_status  = in_range && (word_ofs == regblk_pkg::STATUS_OFS);
  assign sel_hwval   = in_range && (word_ofs == regblk_pkg::HWVAL_OFS);

  // local registers are ready at once, so valid marks the completion edge.
  assign wr_fire = bus_req.valid && (bus_req.access == regblk_pkg::BUS_WRITE);

  assign status_clr = (wr_fire && sel_status && bus_req.strobe[0]) ?
                      bus_req.write_data[regblk_pkg::TRIG_W-1:0] : '0;

  // ************************************************************************
  // field storage.
  // ************************************************************************
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      ctrl_q    <= '0;
      trigger_q <= '0;
      status_q  <= '0;
    end else begin
      if (wr_fire && sel_ctrl) begin
        ctrl_q <= regblk_pkg::apply_strobe(ctrl_q, bus_req.write_data, bus_req.strobe);
      end
      trigger_q <= (wr_fire && sel_trigger && bus_req.strobe[0]) ?
                   bus_req.write_data[regblk_pkg::TRIG_W-1:0] : '0;  // one cycle pulse.
      status_q  <= (status_q & ~status_clr) | i_status_set;  // set wins.
    end
  end

  assign o_ctrl    = ctrl_q;
  assign o_trigger = trigger_q;
  assign o_status  = status_q;

  // read mux.
  always_comb begin
    local_hit   = 1'b1;
    local_rdata = DEFAULT_READ_DATA;
    if (sel_ctrl) begin
      local_rdata = ctrl_q;
    end else if (sel_trigger) begin
      local_rdata = '0;
    end else if (sel_status) begin
      local_rdata = regblk_pkg::word_t'(status_q);
    end else if (sel_hwval) begin
      local_rdata = i_hw_value;
    end else begin
      local_hit = 1'b0;
    end
  end

  // ************************************************************************
  // response steering and forward port.
  // ************************************************************************
  always_comb begin
    if (win_hit) begin
      bus_rsp = i_fwd_rsp;
    end else begin
      bus_rsp.ready     = bus_req.valid;
      bus_rsp.status    = local_hit ? regblk_pkg::BUS_OKAY : regblk_pkg::BUS_DECODE_ERROR;
      bus_rsp.read_data = local_rdata;
    end
  end

  always_comb begin
    o_fwd_req         = bus_req;
    o_fwd_req.valid   = bus_req.valid && win_hit;
    o_fwd_req.address = regblk_pkg::addr_t'(win_ofs);  // offset inside the window.
  end

endmodule

// File: source/apb_bus_bridge.sv
module apb_bus_bridge (
  input  logic                 clk,
  input  logic                 i_rst_n,
  input  regblk_pkg::bus_req_t i_bus_req,
  output regblk_pkg::bus_rsp_t o_bus_rsp,
  output regblk_pkg::apb_req_t o_apb,
  input  regblk_pkg::apb_rsp_t i_apb
);

  logic is_write;
  logic access_q;  // low is idle or setup, high is access.

  assign is_write = i_bus_req.access == regblk_pkg::BUS_WRITE;

  // ************************************************************************
  // phase machine.
  // ************************************************************************
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      access_q <= 1'b0;
    end else if (!access_q) begin
      access_q <= i_bus_req.valid;  // setup lasts one cycle.
    end else if (i_apb.pready) begin
      access_q <= 1'b0;
    end
  end

  // the request is held upstream until ready, so it drives the APB directly.
  always_comb begin
    o_apb.psel    = i_bus_req.valid || access_q;
    o_apb.penable = access_q;
    o_apb.paddr   = i_bus_req.address;
    o_apb.pwrite  = is_write;
    o_apb.pstrb   = is_write ? i_bus_req.strobe : '0;  // no strobes on reads.
    o_apb.pwdata  = i_bus_req.write_data;
  end

  // ************************************************************************
  // response.
  // ************************************************************************
  always_comb begin
    o_bus_rsp.ready     = access_q && i_apb.pready;
    o_bus_rsp.status    = i_apb.pslverr ? regblk_pkg::BUS_SLAVE_ERROR :
                                          regblk_pkg::BUS_OKAY;
    o_bus_rsp.read_data = i_apb.prdata;
  end

endmodule

// File: source/reg_block_1.sv
module reg_block_1 #(
  parameter regblk_pkg::word_t DEFAULT_READ_DATA = 32'hDEAD_BEAF
) (
  input  logic                 clk,
  input  logic                 i_rst_n,
  input  regblk_pkg::apb_req_t i_apb,
  output regblk_pkg::apb_rsp_t o_apb
);

  localparam int IDX_W = $clog2(regblk_pkg::BLK1_REGS);

  regblk_pkg::bus_req_t bus_req;
  regblk_pkg::bus_rsp_t bus_rsp;
  regblk_pkg::word_t    regs_q [regblk_pkg::BLK1_REGS];
  logic [IDX_W-1:0]     idx;
  logic                 hit;
  logic                 wr_fire;

  apb_reg_adapter u_adapter (
    .i_apb     (i_apb),
    .o_apb     (o_apb),
    .o_bus_req (bus_req),
    .i_bus_rsp (bus_rsp)
  );

  // word index, anything above the register file is unmapped.
  assign idx     = bus_req.address[IDX_W+1:2];
  assign hit     = (bus_req.address >> (IDX_W + 2)) == '0;
  assign wr_fire = bus_req.valid && hit && (bus_req.access == regblk_pkg::BUS_WRITE);

  // ************************************************************************
  // scratch registers.
  // ************************************************************************
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < regblk_pkg::BLK1_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_fire) begin
      regs_q[idx] <= regblk_pkg::apply_strobe(regs_q[idx], bus_req.write_data,
                                              bus_req.strobe);
    end
  end

  always_comb begin
    bus_rsp.ready     = bus_req.valid;  // zero wait states.
    bus_rsp.status    = hit ? regblk_pkg::BUS_OKAY : regblk_pkg::BUS_DECODE_ERROR;
    bus_rsp.read_data = hit ? regs_q[idx] : DEFAULT_READ_DATA;
  end

endmodule

// File: source/regblk_top.sv
module regblk_top #(
  parameter regblk_pkg::addr_t BASE_ADDRESS      = 16'h1000,
  parameter regblk_pkg::word_t DEFAULT_READ_DATA = 32'hDEAD_BEAF
) (
  input  logic                 clk,
  input  logic                 i_rst_n,
  input  regblk_pkg::apb_req_t i_apb,
  output regblk_pkg::apb_rsp_t o_apb,
  output regblk_pkg::word_t    o_ctrl,
  output regblk_pkg::trigger_t o_trigger,
  input  regblk_pkg::trigger_t i_status_set,
  output regblk_pkg::trigger_t o_status,
  input  regblk_pkg::word_t    i_hw_value
);

  regblk_pkg::bus_req_t fwd_req;
  regblk_pkg::bus_rsp_t fwd_rsp;
  regblk_pkg::apb_req_t blk1_apb_req;  // internal APB, bridge to reg_block_1.
  regblk_pkg::apb_rsp_t blk1_apb_rsp;

  reg_block_0 #(
    .BASE_ADDRESS      (BASE_ADDRESS),
    .DEFAULT_READ_DATA (DEFAULT_READ_DATA)
  ) u_reg_block_0 (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_apb        (i_apb),
    .o_apb        (o_apb),
    .o_fwd_req    (fwd_req),
    .i_fwd_rsp    (fwd_rsp),
    .o_ctrl       (o_ctrl),
    .o_trigger    (o_trigger),
    .i_status_set (i_status_set),
    .o_status     (o_status),
    .i_hw_value   (i_hw_value)
  );

  apb_bus_bridge u_bridge (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_bus_req (fwd_req),
    .o_bus_rsp (fwd_rsp),
    .o_apb     (blk1_apb_req),
    .i_apb     (blk1_apb_rsp)
  );

  reg_block_1 #(
    .DEFAULT_READ_DATA (DEFAULT_READ_DATA)
  ) u_reg_block_1 (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_apb   (blk1_apb_req),
    .o_apb   (blk1_apb_rsp)
  );

endmodule

// File: sim/regblk_properties.sv
module regblk_properties (
  input logic                 clk,
  input logic                 i_rst_n,
  input regblk_pkg::apb_req_t i_apb_req,
  input regblk_pkg::apb_rsp_t i_apb_rsp,
  input regblk_pkg::apb_req_t i_blk1_req,
  input regblk_pkg::apb_rsp_t i_blk1_rsp,
  input regblk_pkg::trigger_t i_trigger
);
  timeunit 1ns;
  timeprecision 100ps;

  int assert_failures = 0;  // read by the testbench at the end.

  // ************************************************************************
  // internal APB link, bridge to reg_block_1.
  // ************************************************************************
  assert property (@(posedge clk) disable iff (!i_rst_n)
    i_blk1_req.penable |-> i_blk1_req.psel)
  else begin
    assert_failures++;
    $error("bridge penable high without psel");
  end

  // setup and unfinished access phases keep the request.
  assert property (@(posedge clk) disable iff (!i_rst_n)
    (i_blk1_req.psel && !(i_blk1_req.penable && i_blk1_rsp.pready)) |=>
      (i_blk1_req.psel && $stable({i_blk1_req.paddr, i_blk1_req.pwrite,
                                   i_blk1_req.pstrb, i_blk1_req.pwdata})))
  else begin
    assert_failures++;
    $error("bridge request changed before pready");
  end

  // ************************************************************************
  // external port.
  // ************************************************************************
  assert property (@(posedge clk) disable iff (!i_rst_n)
    i_apb_rsp.pready |-> (i_apb_req.psel && i_apb_req.penable))
  else begin
    assert_failures++;
    $error("pready outside an access phase");
  end

  assert property (@(posedge clk) disable iff (!i_rst_n)
    !(i_apb_req.psel && i_apb_req.penable && i_apb_req.pwrite && i_apb_rsp.pready) |=>
      (i_trigger == '0))
  else begin
    assert_failures++;
    $error("trigger pulse without a completed write");
  end

endmodule

bind regblk_top regblk_properties u_props (
  .clk        (clk),
  .i_rst_n    (i_rst_n),
  .i_apb_req  (i_apb),
  .i_apb_rsp  (o_apb),
  .i_blk1_req (blk1_apb_req),
  .i_blk1_rsp (blk1_apb_rsp),
  .i_trigger  (o_trigger)
);

// File: sim/regblk_tb.sv
module regblk_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam regblk_pkg::addr_t BASE       = 16'h1000;
  localparam regblk_pkg::word_t DEFAULT_RD = 32'hDEAD_BEAF;
  localparam int NUM_OPS  = 400;
  localparam int MAX_WAIT = 16;

  typedef enum {T_CTRL, T_TRIGGER, T_STATUS, T_HWVAL, T_SCRATCH, T_NONE} target_e;

  logic                 clk = 1'b0;
  logic                 i_rst_n;
  regblk_pkg::apb_req_t i_apb;
  regblk_pkg::apb_rsp_t o_apb;
  regblk_pkg::word_t    o_ctrl;
  regblk_pkg::trigger_t o_trigger;
  regblk_pkg::trigger_t i_status_set;
  regblk_pkg::trigger_t o_status;
  regblk_pkg::word_t    i_hw_value;

  logic [31:0] lfsr_state = 32'hbd7a_aaad;
  int          errors = 0;
  int          checks = 0;
  logic        run_checks = 1'b0;

  // reference model.
  regblk_pkg::word_t    ctrl_m = '0;
  regblk_pkg::word_t    scratch_m [4];
  regblk_pkg::trigger_t status_m = '0;
  regblk_pkg::trigger_t exp_trig = '0;
  regblk_pkg::trigger_t pending_clr = '0;   // set at the completion cycle.
  regblk_pkg::trigger_t pending_trig = '0;

  regblk_top #(
    .BASE_ADDRESS      (BASE),
    .DEFAULT_READ_DATA (DEFAULT_RD)
  ) regblk_top_i (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_apb        (i_apb),
    .o_apb        (o_apb),
    .o_ctrl       (o_ctrl),
    .o_trigger    (o_trigger),
    .i_status_set (i_status_set),
    .o_status     (o_status),
    .i_hw_value   (i_hw_value)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic regblk_pkg::word_t merge_bytes(regblk_pkg::word_t old_w,
                                                    regblk_pkg::word_t new_w,
                                                    regblk_pkg::strb_t strb);
    regblk_pkg::word_t mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  function automatic target_e decode_target(regblk_pkg::addr_t addr);
    int rel;
    rel = int'(addr) - int'(BASE);
    if (rel < 0 || rel >= 'h200) return T_NONE;
    if (rel == 'h000) return T_CTRL;
    if (rel == 'h004) return T_TRIGGER;
    if (rel == 'h008) return T_STATUS;
    if (rel == 'h00C) return T_HWVAL;
    if (rel >= 'h100 && rel < 'h110) return T_SCRATCH;
    return T_NONE;
  endfunction

  // ************************************************************************
  // compare tasks.
  // ************************************************************************
  task automatic check_word(string name, regblk_pkg::word_t exp, regblk_pkg::word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error at %0d ns: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_status(string name, regblk_pkg::trigger_t exp,
                              regblk_pkg::trigger_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error at %0d ns: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_err(string name, logic exp, logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error at %0d ns: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  // ************************************************************************
  // stimulus.
  // ************************************************************************
  // setup, access, then back at the negedge where pready is seen.
  task automatic apb_transfer(input regblk_pkg::addr_t addr, input logic write,
                              input regblk_pkg::word_t wdata, input regblk_pkg::strb_t strb,
                              input regblk_pkg::word_t hw, output regblk_pkg::word_t rdata,
                              output logic err, output logic done);
    regblk_pkg::apb_req_t req;
    int                   waits;
    req = '{psel: 1'b1, penable: 1'b0, paddr: addr, pwrite: write,
            pstrb: write ? strb : '0, pwdata: wdata};
    waits = 0;
    done  = 1'b0;
    rdata = '0;
    err   = 1'b0;
    @(posedge clk);
    i_apb      <= req;
    i_hw_value <= hw;
    @(posedge clk);
    req.penable = 1'b1;
    i_apb <= req;
    while (!done && waits < MAX_WAIT) begin
      @(negedge clk);
      if (o_apb.pready === 1'b1) begin
        done  = 1'b1;
        rdata = o_apb.prdata;
        err   = o_apb.pslverr;
      end else begin
        waits++;
        @(posedge clk);
      end
    end
  endtask

  task automatic run_op(regblk_pkg::addr_t addr, logic write, regblk_pkg::word_t wdata,
                        regblk_pkg::strb_t strb, regblk_pkg::word_t hw);
    target_e           tgt;
    regblk_pkg::word_t exp_data;
    regblk_pkg::word_t rdata;
    logic              err;
    logic              done;
    int                idx;
    tgt = decode_target(addr);
    idx = ((int'(addr) - int'(BASE)) >> 2) & 3;
    apb_transfer(addr, write, wdata, strb, hw, rdata, err, done);
    if (!done) begin
      errors++;
      $display("Error at %0d ns: no pready within %0d cycles of the access phase",
               $time, MAX_WAIT);
    end else begin
      case (tgt)
        T_CTRL:    exp_data = ctrl_m;
        T_TRIGGER: exp_data = '0;
        T_STATUS:  exp_data = regblk_pkg::word_t'(status_m);
        T_HWVAL:   exp_data = hw;
        T_SCRATCH: exp_data = scratch_m[idx];
        default:   exp_data = DEFAULT_RD;
      endcase
      check_err("o_apb.pslverr", tgt == T_NONE, err);
      if (!write) check_word("o_apb.prdata", exp_data, rdata);
      if (write && strb[0] && tgt == T_STATUS) pending_clr = wdata[3:0];
      if (write && strb[0] && tgt == T_TRIGGER) pending_trig = wdata[3:0];
    end
    @(posedge clk);
    i_apb <= '0;
    if (done && write && tgt == T_CTRL) ctrl_m = merge_bytes(ctrl_m, wdata, strb);
    if (done && write && tgt == T_SCRATCH) begin
      scratch_m[idx] = merge_bytes(scratch_m[idx], wdata, strb);
    end
  endtask

  task automatic draw_op(output regblk_pkg::addr_t addr, output logic write,
                         output regblk_pkg::word_t wdata, output regblk_pkg::strb_t strb);
    logic [3:0] pick;
    int         ofs;
    pick  = 4'(rand_bits(4));
    write = 1'(rand_bits(1));
    wdata = rand_bits(32);
    strb  = regblk_pkg::strb_t'(rand_bits(4));
    case (pick)
      0, 1, 2:          ofs = 'h000;
      3, 4:             ofs = 'h004;
      5, 6:             ofs = 'h008;
      7:                ofs = 'h00C;
      8, 9, 10, 11, 12: ofs = 'h100 + 4 * int'(rand_bits(2));
      13:      ofs = rand_bits(1) ? 'h010 + 4 * int'(rand_bits(5)) :
                                   'h180 + 4 * int'(rand_bits(5));
      14:      ofs = 'h110 + 4 * int'(rand_bits(4));  // window, past the scratch words.
      default: ofs = rand_bits(1) ? 'h200 + 4 * int'(rand_bits(10)) :
                                   -4 * (1 + int'(rand_bits(8)));
    endcase
    addr = regblk_pkg::addr_t'(int'(BASE) + ofs);
  endtask

  // sparse set pulses so that clears stay visible.
  always @(posedge clk) begin
    if (rand_bits(2) == 0) i_status_set <= regblk_pkg::trigger_t'(rand_bits(4));
    else i_status_set <= '0;
  end

  always @(posedge clk) begin
    if (!i_rst_n) begin
      status_m = '0;
      exp_trig = '0;
    end else begin
      status_m = (status_m & ~pending_clr) | i_status_set;  // set wins.
      exp_trig = pending_trig;
    end
    pending_clr  = '0;
    pending_trig = '0;
  end

  always @(negedge clk) begin
    if (run_checks) begin
      check_word("o_ctrl", ctrl_m, o_ctrl);
      check_status("o_status", status_m, o_status);
      check_status("o_trigger", exp_trig, o_trigger);
    end
  end

  initial begin
    #((NUM_OPS + 8) * 8 * 20 + 1000);
    $display("Error at %0d ns: watchdog expired before the test sequence ended", $time);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    regblk_pkg::addr_t addr;
    logic              write;
    regblk_pkg::word_t wdata;
    regblk_pkg::strb_t strb;
    int                total;
    i_rst_n      = 1'b0;
    i_apb        = '0;
    i_status_set = '0;
    i_hw_value   = '0;
    for (int i = 0; i < 4; i++) scratch_m[i] = '0;
    repeat (2) @(posedge clk);
    i_rst_n <= 1'b1;
    run_checks = 1'b1;

    // reset values first.
    run_op(BASE, 1'b0, '0, '0, '0);
    run_op(BASE + 16'h004, 1'b0, '0, '0, '0);
    for (int i = 0; i < 4; i++) begin
      run_op(regblk_pkg::addr_t'(BASE + 16'h100 + 4 * i), 1'b0, '0, '0, '0);
    end

    for (int n = 0; n < NUM_OPS; n++) begin
      @(negedge clk);
      draw_op(addr, write, wdata, strb);
      run_op(addr, write, wdata, strb, rand_bits(32));
    end

    total = errors + regblk_top_i.u_props.assert_failures;
    $display("errors: %0d (%0d checks, %0d assertion failures)",
             total, checks, regblk_top_i.u_props.assert_failures);
    if (total == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: all.f
source/regblk_pkg.sv
source/apb_reg_adapter.sv
source/reg_block_0.sv
source/apb_bus_bridge.sv
source/reg_block_1.sv
source/regblk_top.sv
sim/regblk_properties.sv
sim/regblk_tb.sv
